//--- src/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------------
    // Datapath sizes
    // ------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Bytes per instruction word, one fetch step
    localparam int INST_BYTES = 4;

    // ------------------------------------------------------------------
    // Major opcodes of the supported integer subset
    // ------------------------------------------------------------------
    typedef enum logic [6:0] {
        // add, sub, and, or, xor, slt, sll, srl
        op_rtype  = 7'b0110011,
        // addi, andi, ori, xori, slti
        op_itype  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        // beq and bne
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // ------------------------------------------------------------------
    // ALU operations
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        // Signed compare, result is 0 or 1
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_t;

endpackage

//--- src/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    input  logic [XLEN-1:0] imm,
    input  logic            use_imm,
    input  alu_op_t         op,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] operand_b;
    logic [4:0]      shamt;

    // Second operand, register or immediate
    assign operand_b = use_imm ? imm : rs2_val;
    // Shift amount from the low 5 bits
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (op)
            alu_add: result = rs1_val + operand_b;
            alu_sub: result = rs1_val - operand_b;
            alu_and: result = rs1_val & operand_b;
            alu_or:  result = rs1_val | operand_b;
            alu_xor: result = rs1_val ^ operand_b;
            // Signed less-than
            alu_slt: result = XLEN'($signed(rs1_val) < $signed(operand_b));
            alu_sll: result = rs1_val << shamt;
            // Logical right shift
            alu_srl: result = rs1_val >> shamt;
            default: result = '0;
        endcase
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we1,
    input  logic                  we2,
    input  logic [REG_ADDR_W-1:0] wr_addr1,
    input  logic [REG_ADDR_W-1:0] wr_addr2,
    input  logic [XLEN-1:0]       wr_data1,
    input  logic [XLEN-1:0]       wr_data2,
    input  logic [REG_ADDR_W-1:0] rd_addr1_1,
    input  logic [REG_ADDR_W-1:0] rd_addr2_1,
    input  logic [REG_ADDR_W-1:0] rd_addr1_2,
    input  logic [REG_ADDR_W-1:0] rd_addr2_2,
    output logic [XLEN-1:0]       rd_data1_1,
    output logic [XLEN-1:0]       rd_data2_1,
    output logic [XLEN-1:0]       rd_data1_2,
    output logic [XLEN-1:0]       rd_data2_2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // One read port with write bypass, slot 2 write is the younger one
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we2 && (wr_addr2 == addr)) begin
            value = wr_data2;
        end else if (we1 && (wr_addr1 == addr)) begin
            value = wr_data1;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // Four read ports, two per slot
    always_comb rd_data1_1 = read_port(rd_addr1_1);
    always_comb rd_data2_1 = read_port(rd_addr2_1);
    always_comb rd_data1_2 = read_port(rd_addr1_2);
    always_comb rd_data2_2 = read_port(rd_addr2_2);

    // Two write ports
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1) begin
                regs[wr_addr1] <= wr_data1;
            end
            if (we2) begin
                regs[wr_addr2] <= wr_data2;
            end
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import cpu_pkg::*; (
    input  logic [XLEN-1:0]       inst,
    output opcode_t               opcode,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       imm,
    output alu_op_t               alu_op,
    output logic                  use_imm,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  branch_ne
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    // Field slicing
    assign opcode = opcode_t'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // ------------------------------------------------------------------
    // Control flags
    // ------------------------------------------------------------------
    assign use_imm   = opcode inside {op_itype, op_load, op_store};
    assign mem_read  = (opcode == op_load);
    assign mem_write = (opcode == op_store);
    assign is_branch = (opcode == op_branch);
    assign is_jal    = (opcode == op_jal);
    // funct3 001 selects bne, 000 beq
    assign branch_ne = is_branch && (funct3 == 3'b001);

    // Writes to x0 are dropped here once for the whole core
    assign reg_write = (opcode inside {op_rtype, op_itype, op_load, op_jal}) && (rd != '0);

    // ------------------------------------------------------------------
    // Sign-extended immediate, format chosen by opcode
    // ------------------------------------------------------------------
    always_comb begin
        case (opcode)
            op_itype, op_load: imm = {{20{inst[31]}}, inst[31:20]};
            op_store:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            op_branch: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            op_jal: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:           imm = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // ALU operation
    // ------------------------------------------------------------------
    always_comb begin
        alu_op = alu_add;
        if (opcode == op_branch) begin
            // Branch compares through the subtractor
            alu_op = alu_sub;
        end else if (opcode inside {op_rtype, op_itype}) begin
            case (funct3)
                // Sub only exists in R-type
                3'b000:  alu_op = (opcode == op_rtype && funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = alu_srl;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

endmodule

//--- src/issue_logic.sv
`timescale 1ns/100ps

module issue_logic import cpu_pkg::*; (
    input  logic                  pair_valid,
    input  logic [REG_ADDR_W-1:0] rd_1,
    input  logic                  reg_write_1,
    input  logic                  mem_read_1,
    input  logic                  mem_write_1,
    input  logic                  is_branch_1,
    input  logic                  is_jal_1,
    input  logic [REG_ADDR_W-1:0] rd_2,
    input  logic [REG_ADDR_W-1:0] rs1_2,
    input  logic [REG_ADDR_W-1:0] rs2_2,
    input  logic                  reg_write_2,
    input  logic                  mem_read_2,
    input  logic                  mem_write_2,
    input  logic                  is_branch_2,
    input  logic                  is_jal_2,
    output logic                  issue_second,
    output logic                  fwd_rs1,
    output logic                  fwd_rs2
);

    logic waw_hazard;
    logic mem_in_pair;
    logic ctrl_in_pair;

    // Both slots target the same register
    assign waw_hazard   = reg_write_1 && reg_write_2 && (rd_1 == rd_2);
    // Single data port, so memory ops always run alone
    assign mem_in_pair  = mem_read_1 || mem_write_1 || mem_read_2 || mem_write_2;
    // Control transfer in slot 2 waits for promotion
    assign ctrl_in_pair = is_branch_1 || is_jal_1 || is_branch_2 || is_jal_2;

    assign issue_second = pair_valid && !waw_hazard && !mem_in_pair && !ctrl_in_pair;

    // Slot 1 ALU result feeds slot 2 operands
    assign fwd_rs1 = reg_write_1 && (rd_1 == rs1_2);
    assign fwd_rs2 = reg_write_1 && (rd_1 == rs2_2);

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] imem_inst1,
    input  logic [XLEN-1:0] imem_inst2,
    input  logic            take_both,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] slot1_pc,
    output logic [XLEN-1:0] slot1_inst,
    output logic [XLEN-1:0] slot2_inst,
    output logic            pair_valid
);

    // Address of the next word not yet held in the slots
    logic [XLEN-1:0] fetch_pc;
    // Whole new pair loaded from imem
    logic            reload_pair;

    assign imem_addr   = fetch_pc;
    assign reload_pair = !pair_valid || take_both;

    // ------------------------------------------------------------------
    // Fetch address and window state
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc   <= RESET_PC;
            pair_valid <= 1'b0;
        end else if (redirect) begin
            // Drop the window, refill from the target next edge
            fetch_pc   <= redirect_pc;
            pair_valid <= 1'b0;
        end else if (reload_pair) begin
            fetch_pc   <= fetch_pc + XLEN'(2 * INST_BYTES);
            pair_valid <= 1'b1;
        end else begin
            // Only slot 1 retired, window slides by one word
            fetch_pc <= fetch_pc + XLEN'(INST_BYTES);
        end
    end

    // ------------------------------------------------------------------
    // Instruction pair
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reload_pair) begin
            slot1_inst <= imem_inst1;
            slot2_inst <= imem_inst2;
            slot1_pc   <= fetch_pc;
        end else begin
            // Promote slot 2, slot 2 takes the word at the fetch address
            slot1_inst <= slot2_inst;
            slot2_inst <= imem_inst1;
            slot1_pc   <= slot1_pc + XLEN'(INST_BYTES);
        end
    end

endmodule

//--- src/dual_issue_cpu.sv
`timescale 1ns/100ps

module dual_issue_cpu import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] imem_inst1,
    input  logic [XLEN-1:0] imem_inst2,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic [XLEN-1:0] imem_addr,
    output logic [XLEN-1:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_we
);

    // Fetch window
    logic [XLEN-1:0] slot1_pc, slot1_inst, slot2_inst;
    logic            pair_valid;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    // Decoded slot 1
    opcode_t               opcode_1;
    logic [REG_ADDR_W-1:0] rd_1, rs1_1, rs2_1;
    logic [XLEN-1:0]       imm_1;
    alu_op_t               alu_op_1;
    logic use_imm_1, reg_write_1, mem_read_1, mem_write_1;
    logic is_branch_1, is_jal_1, branch_ne_1;

    // Decoded slot 2
    logic [REG_ADDR_W-1:0] rd_2, rs1_2, rs2_2;
    logic [XLEN-1:0]       imm_2;
    alu_op_t               alu_op_2;
    logic use_imm_2, reg_write_2, mem_read_2, mem_write_2;
    logic is_branch_2, is_jal_2;

    // Issue and operands
    logic            issue_second, fwd_rs1, fwd_rs2;
    logic [XLEN-1:0] rs1_val_1, rs2_val_1, rs1_val_2, rs2_val_2;
    logic [XLEN-1:0] rs1_fwd_2, rs2_fwd_2;
    logic [XLEN-1:0] result_1, result_2;
    logic            branch_taken;

    // Writeback registers
    logic                  wb_we_1, wb_we_2;
    logic [REG_ADDR_W-1:0] wb_rd_1, wb_rd_2;
    logic [XLEN-1:0]       wb_data_1, wb_data_2, wb_src_1;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_inst (
        .clk(clk), .reset(reset),
        .imem_inst1(imem_inst1), .imem_inst2(imem_inst2),
        .take_both(issue_second), .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .slot1_pc(slot1_pc),
        .slot1_inst(slot1_inst), .slot2_inst(slot2_inst), .pair_valid(pair_valid)
    );

    inst_decoder decoder_1_inst (
        .inst(slot1_inst), .opcode(opcode_1), .rd(rd_1), .rs1(rs1_1), .rs2(rs2_1),
        .imm(imm_1), .alu_op(alu_op_1), .use_imm(use_imm_1), .reg_write(reg_write_1),
        .mem_read(mem_read_1), .mem_write(mem_write_1), .is_branch(is_branch_1),
        .is_jal(is_jal_1), .branch_ne(branch_ne_1)
    );

    // Slot 2 never resolves a branch, opcode and branch sense unused
    inst_decoder decoder_2_inst (
        .inst(slot2_inst), .opcode(), .rd(rd_2), .rs1(rs1_2), .rs2(rs2_2),
        .imm(imm_2), .alu_op(alu_op_2), .use_imm(use_imm_2), .reg_write(reg_write_2),
        .mem_read(mem_read_2), .mem_write(mem_write_2), .is_branch(is_branch_2),
        .is_jal(is_jal_2), .branch_ne()
    );

    issue_logic issue_logic_inst (
        .pair_valid(pair_valid),
        .rd_1(rd_1), .reg_write_1(reg_write_1), .mem_read_1(mem_read_1),
        .mem_write_1(mem_write_1), .is_branch_1(is_branch_1), .is_jal_1(is_jal_1),
        .rd_2(rd_2), .rs1_2(rs1_2), .rs2_2(rs2_2), .reg_write_2(reg_write_2),
        .mem_read_2(mem_read_2), .mem_write_2(mem_write_2),
        .is_branch_2(is_branch_2), .is_jal_2(is_jal_2),
        .issue_second(issue_second), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
    );

    register_file register_file_inst (
        .clk(clk), .reset(reset), .we1(wb_we_1), .we2(wb_we_2),
        .wr_addr1(wb_rd_1), .wr_addr2(wb_rd_2), .wr_data1(wb_data_1), .wr_data2(wb_data_2),
        .rd_addr1_1(rs1_1), .rd_addr2_1(rs2_1), .rd_addr1_2(rs1_2), .rd_addr2_2(rs2_2),
        .rd_data1_1(rs1_val_1), .rd_data2_1(rs2_val_1),
        .rd_data1_2(rs1_val_2), .rd_data2_2(rs2_val_2)
    );

    // ------------------------------------------------------------------
    // Execute, slot 2 sees slot 1 result through the forward muxes
    // ------------------------------------------------------------------
    assign rs1_fwd_2 = fwd_rs1 ? result_1 : rs1_val_2;
    assign rs2_fwd_2 = fwd_rs2 ? result_1 : rs2_val_2;

    alu alu_1_inst (
        .rs1_val(rs1_val_1), .rs2_val(rs2_val_1), .imm(imm_1),
        .use_imm(use_imm_1), .op(alu_op_1), .result(result_1)
    );

    alu alu_2_inst (
        .rs1_val(rs1_fwd_2), .rs2_val(rs2_fwd_2), .imm(imm_2),
        .use_imm(use_imm_2), .op(alu_op_2), .result(result_2)
    );

    // Branch resolves on the slot 1 difference, beq on zero
    assign branch_taken = is_branch_1 && (branch_ne_1 ? (result_1 != '0) : (result_1 == '0));
    assign redirect     = pair_valid && (is_jal_1 || branch_taken);
    // Imm already holds the B or J offset
    assign redirect_pc  = slot1_pc + imm_1;

    // Data port belongs to slot 1
    assign dmem_addr  = result_1;
    assign dmem_wdata = rs2_val_1;
    assign dmem_we    = pair_valid && mem_write_1;

    // ------------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------------
    always_comb begin
        case (opcode_1)
            op_load: wb_src_1 = dmem_rdata;
            // Link value
            op_jal:  wb_src_1 = slot1_pc + XLEN'(INST_BYTES);
            default: wb_src_1 = result_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we_1 <= 1'b0;
            wb_we_2 <= 1'b0;
        end else begin
            wb_we_1 <= pair_valid && reg_write_1;
            // Squashed when slot 1 redirects
            wb_we_2 <= issue_second && !redirect && reg_write_2;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_1   <= rd_1;
        wb_rd_2   <= rd_2;
        wb_data_1 <= wb_src_1;
        wb_data_2 <= result_2;
    end

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb import cpu_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC = '0;
    // Cycles allowed for the program to reach its final store
    localparam int DONE_TIMEOUT = 400;
    // Quiet cycles watched after the final store
    localparam int TAIL_CYCLES  = 20;

    logic            clk = 1'b0;
    logic            reset;
    logic [XLEN-1:0] imem_inst1, imem_inst2, dmem_rdata;
    logic [XLEN-1:0] imem_addr, dmem_addr, dmem_wdata;
    logic            dmem_we;

    // Memory models and expected stores
    logic [XLEN-1:0] rom [64];
    logic [XLEN-1:0] ram [256];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              exp_idx = 0;
    int              mismatch_errors = 0;
    int              other_errors = 0;
    logic            done_seen = 1'b0;

    dual_issue_cpu #(.RESET_PC(RESET_PC)) dual_issue_cpu_inst (
        .clk(clk), .reset(reset),
        .imem_inst1(imem_inst1), .imem_inst2(imem_inst2), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_we(dmem_we)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // ----------------------------------------------------------------------
    // Combinational memories with word addressing
    // ----------------------------------------------------------------------
    assign imem_inst1 = rom[imem_addr[7:2]];
    assign imem_inst2 = rom[imem_addr[7:2] + 6'd1];
    assign dmem_rdata = ram[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // Program words and expected stores from the stim file
    task automatic load_stim();
        int    fd;
        int    code;
        int    n_words;
        string line;
        logic [XLEN-1:0] word, addr;
        n_words = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = '0;
        end
        fd = $fopen("testbench/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file testbench/cpu_stim.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // A read at end of file returns no characters
                if (code > 0) begin
                    if ($sscanf(line, "I %h", word) == 1) begin
                        rom[n_words] = word;
                        n_words++;
                    end else if ($sscanf(line, "E %h %h", addr, word) == 2) begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(word);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------------------------------------
    // Store monitor samples mid-cycle where the port is stable
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && dmem_we === 1'b1) begin
            if (exp_idx >= exp_addr.size()) begin
                $display("Unexpected extra store to address %h at time %0t", dmem_addr, $time);
                other_errors++;
            end else begin
                assert (dmem_addr == exp_addr[exp_idx] && dmem_wdata == exp_data[exp_idx])
                else begin
                    $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, exp_idx, dmem_wdata, dmem_addr,
                             exp_data[exp_idx], exp_addr[exp_idx]);
                    mismatch_errors++;
                end
                // Last record is the done store
                if (exp_idx == exp_addr.size() - 1) begin
                    done_seen = 1'b1;
                end
                exp_idx++;
            end
        end
    end

    initial begin
        int cycles;
        reset = 1'b1;
        load_stim();

        // Reset held for 3 cycles and released just after the edge
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        #10 reset = 1'b0;

        // Nothing executes before the first pair is loaded
        assert (dmem_we == 1'b0 && imem_addr == RESET_PC)
        else begin
            $display("** Error at %0t: after reset dmem_we=%b imem_addr=%h",
                     $time, dmem_we, imem_addr);
            mismatch_errors++;
        end

        cycles = 0;
        while (!done_seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end

        if (!done_seen) begin
            $display("Timeout: no store to the done address within %0d cycles", DONE_TIMEOUT);
            other_errors++;
        end else begin
            // Core spins on its final jal so any store now is extra
            for (int i = 0; i < TAIL_CYCLES; i++) begin
                @(posedge clk);
            end
        end

        if (exp_idx < exp_addr.size()) begin
            $display("Only %0d of %0d expected stores were seen", exp_idx, exp_addr.size());
            other_errors++;
        end

        $display("Error counts: %0d value mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/cpu_stim.txt
# I <word>: program word, loaded from address 0 upward
# E <addr> <data>: expected store in order, the last one is the done store
I 00500093
I 00700113
I 002081B3
I 40118233
I 0021C2B3
I 0012E333
I 004373B3
I 0070A433
I 008314B3
I 0084D533
I 00657593
I 0305E613
I FFF64693
I 0006A713
I 00970793
I 00270793
I 04402023
I 04A02223
I 04F02423
I 04D02623
I 04002803
I 010808B3
I 05102823
I 04302A23
I 05402903
I 05202C23
I 00108463
I 06102023
I 00109463
I 06202223
I 008009EF
I 06102423
I 07302623
I 10202023
I 0000006F
E 00000040 00000007
E 00000044 0000000F
E 00000048 00000003
E 0000004C FFFFFFC9
E 00000050 0000000E
E 00000054 0000000C
E 00000058 0000000C
E 00000064 00000007
E 0000006C 0000007C
E 00000100 00000007

//--- verilog.f
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/inst_decoder.sv
src/issue_logic.sv
src/fetch_unit.sv
src/dual_issue_cpu.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, pass is decided by the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f verilog.f -o cpu_sim &&
./obj_dir/cpu_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
